/* execPkg.sv */
package execPkg;

    ////////////////////
    // ALU operations
    ////////////////////

    // Internal ALU op code, one per ALU case item
    typedef enum logic [4:0] {
        ADD   = 5'd0,
        SUB   = 5'd1,
        AND   = 5'd2,
        OR    = 5'd3,
        NOR   = 5'd4,
        XOR   = 5'd5,
        SLT   = 5'd6,
        SLTU  = 5'd7,
        SLL   = 5'd8,
        SRL   = 5'd9,
        SRA   = 5'd10,
        ROTR  = 5'd11,
        SLLV  = 5'd12,
        SRLV  = 5'd13,
        ROTRV = 5'd14,
        SEB   = 5'd15,
        SEH   = 5'd16,
        MULT  = 5'd17,
        MULTU = 5'd18,
        // Also used for MFHI/MFLO and illegal words
        PASSB = 5'd19
    } aluOpE;

    ////////////////////
    // MIPS encodings
    ////////////////////

    // Major opcode field instr[31:26]
    typedef enum logic [5:0] {
        OpSpecial  = 6'h00,
        OpAddi     = 6'h08,
        OpAddiu    = 6'h09,
        OpSlti     = 6'h0A,
        OpSltiu    = 6'h0B,
        OpAndi     = 6'h0C,
        OpOri      = 6'h0D,
        OpXori     = 6'h0E,
        OpSpecial3 = 6'h1F
    } opcodeE;

    // Funct field instr[5:0] under SPECIAL
    typedef enum logic [5:0] {
        FnSll   = 6'h00,
        FnSrl   = 6'h02,
        FnSra   = 6'h03,
        FnSllv  = 6'h04,
        FnSrlv  = 6'h06,
        FnMfhi  = 6'h10,
        FnMflo  = 6'h12,
        FnMult  = 6'h18,
        FnMultu = 6'h19,
        FnAdd   = 6'h20,
        FnAddu  = 6'h21,
        FnSub   = 6'h22,
        FnSubu  = 6'h23,
        FnAnd   = 6'h24,
        FnOr    = 6'h25,
        FnXor   = 6'h26,
        FnNor   = 6'h27,
        FnSlt   = 6'h2A,
        FnSltu  = 6'h2B
    } functE;

    // SPECIAL3 byte shuffle group, sub-op in the sa field
    localparam logic [5:0] FnBshfl = 6'h20;
    localparam logic [4:0] SaSeb   = 5'h10;
    localparam logic [4:0] SaSeh   = 5'h18;

    ////////////////////
    // Stage structs
    ////////////////////

    // Decoder output, 13 bits
    typedef struct packed {
        aluOpE aluOp;
        logic  useImm;
        logic  immSigned;
        // Shift amount from rs[4:0] instead of sa
        logic  varShift;
        // Operand A taken from rt
        logic  shiftRt;
        logic  hiLoWrite;
        logic  readHi;
        logic  readLo;
        logic  illegal;
    } decodedT;

    // Registered stage response
    typedef struct packed {
        logic        valid;
        logic [31:0] result;
        logic        zero;
        logic        illegal;
    } execRespT;

endpackage

/* aluCore.sv */
`timescale 1ns/1ps

module aluCore (
    input  execPkg::aluOpE aluOp,
    input  logic [31:0]    a,
    input  logic [31:0]    b,
    input  logic [4:0]     shamt,
    output logic [63:0]    result,
    output logic           zero
);
    import execPkg::*;

    // Left shift count that completes a rotate
    logic [5:0] rotLeft;

    // 32 minus shamt, 6 bits so a zero rotate gives 32
    assign rotLeft = 6'd32 - {1'b0, shamt};

    ////////////////////
    // Operation select
    ////////////////////

    always_comb begin
        // Upper word stays zero except for multiplies
        result = '0;
        case (aluOp)
            // Arithmetic, no overflow trap
            ADD: begin
                result[31:0] = a + b;
            end
            SUB: begin
                result[31:0] = a - b;
            end

            // Bitwise logic
            AND: begin
                result[31:0] = a & b;
            end
            OR: begin
                result[31:0] = a | b;
            end
            NOR: begin
                result[31:0] = ~(a | b);
            end
            XOR: begin
                result[31:0] = a ^ b;
            end

            // Compares yield 0 or 1
            SLT: begin
                result[0] = $signed(a) < $signed(b);
            end
            SLTU: begin
                result[0] = a < b;
            end

            // Shifts by sa or rs, both arrive on shamt
            SLL, SLLV: begin
                result[31:0] = a << shamt;
            end
            SRL, SRLV: begin
                result[31:0] = a >> shamt;
            end
            SRA: begin
                // Sign bit of a fills from the left
                result[31:0] = $signed(a) >>> shamt;
            end
            ROTR, ROTRV: begin
                // Bits shifted out on the right wrap to the top
                result[31:0] = (a >> shamt) | (a << rotLeft);
            end

            // Sign extension of operand b
            SEB: begin
                result[31:0] = {{24{b[7]}}, b[7:0]};
            end
            SEH: begin
                result[31:0] = {{16{b[15]}}, b[15:0]};
            end

            ////////////////////
            // Multiplies
            ////////////////////

            MULT: begin
                // Signed operands widen to 64 bits with sign
                result = $signed(a) * $signed(b);
            end
            MULTU: begin
                // Zero extended to 64 bits before the product
                result = a * b;
            end

            // MFHI, MFLO and illegal words route b through
            PASSB: begin
                result[31:0] = b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // Flag over the full 64-bit result
    assign zero = (result == '0);

endmodule

/* aluDecode.sv */
`timescale 1ns/1ps

module aluDecode (
    input  logic [31:0]      instr,
    output execPkg::decodedT dec
);
    import execPkg::*;

    opcodeE     opcode;
    functE      funct;
    logic [4:0] sa;

    // Field split
    assign opcode = opcodeE'(instr[31:26]);
    assign funct  = functE'(instr[5:0]);
    assign sa     = instr[10:6];

    always_comb begin
        // Default is an illegal-free pass of b
        dec       = '0;
        dec.aluOp = PASSB;
        case (opcode)
            ////////////////////
            // R-type
            ////////////////////
            OpSpecial: begin
                case (funct)
                    FnAdd, FnAddu: dec.aluOp = ADD;
                    FnSub, FnSubu: dec.aluOp = SUB;
                    FnAnd:         dec.aluOp = AND;
                    FnOr:          dec.aluOp = OR;
                    FnXor:         dec.aluOp = XOR;
                    FnNor:         dec.aluOp = NOR;
                    FnSlt:         dec.aluOp = SLT;
                    FnSltu:        dec.aluOp = SLTU;
                    // Shifts by sa act on rt
                    FnSll: begin
                        dec.aluOp   = SLL;
                        dec.shiftRt = 1'b1;
                    end
                    FnSrl: begin
                        // Bit 21 turns SRL into ROTR
                        if (instr[21]) begin
                            dec.aluOp = ROTR;
                        end else begin
                            dec.aluOp = SRL;
                        end
                        dec.shiftRt = 1'b1;
                    end
                    FnSra: begin
                        dec.aluOp   = SRA;
                        dec.shiftRt = 1'b1;
                    end
                    // Variable shifts take the amount from rs
                    FnSllv: begin
                        dec.aluOp    = SLLV;
                        dec.shiftRt  = 1'b1;
                        dec.varShift = 1'b1;
                    end
                    FnSrlv: begin
                        // Bit 6 turns SRLV into ROTRV
                        if (instr[6]) begin
                            dec.aluOp = ROTRV;
                        end else begin
                            dec.aluOp = SRLV;
                        end
                        dec.shiftRt  = 1'b1;
                        dec.varShift = 1'b1;
                    end
                    // Multiplies load HI/LO
                    FnMult: begin
                        dec.aluOp     = MULT;
                        dec.hiLoWrite = 1'b1;
                    end
                    FnMultu: begin
                        dec.aluOp     = MULTU;
                        dec.hiLoWrite = 1'b1;
                    end
                    FnMfhi:  dec.readHi  = 1'b1;
                    FnMflo:  dec.readLo  = 1'b1;
                    default: dec.illegal = 1'b1;
                endcase
            end

            ////////////////////
            // I-type
            ////////////////////
            OpAddi, OpAddiu: begin
                dec.aluOp     = ADD;
                dec.useImm    = 1'b1;
                dec.immSigned = 1'b1;
            end
            OpSlti: begin
                dec.aluOp     = SLT;
                dec.useImm    = 1'b1;
                dec.immSigned = 1'b1;
            end
            OpSltiu: begin
                // Sign-extended imm, unsigned compare
                dec.aluOp     = SLTU;
                dec.useImm    = 1'b1;
                dec.immSigned = 1'b1;
            end
            // Logic immediates are zero-extended
            OpAndi: begin
                dec.aluOp  = AND;
                dec.useImm = 1'b1;
            end
            OpOri: begin
                dec.aluOp  = OR;
                dec.useImm = 1'b1;
            end
            OpXori: begin
                dec.aluOp  = XOR;
                dec.useImm = 1'b1;
            end

            // SEB/SEH via BSHFL, sub-op in sa
            OpSpecial3: begin
                if (instr[5:0] == FnBshfl && sa == SaSeb) begin
                    dec.aluOp = SEB;
                end else if (instr[5:0] == FnBshfl && sa == SaSeh) begin
                    dec.aluOp = SEH;
                end else begin
                    dec.illegal = 1'b1;
                end
            end
            default: dec.illegal = 1'b1;
        endcase
    end

endmodule

/* hiLoRegs.sv */
`timescale 1ns/1ps

module hiLoRegs (
    input  logic        Clk,
    input  logic        arstN,
    input  logic        we,
    input  logic [63:0] product,
    output logic [31:0] hi,
    output logic [31:0] lo
);

    ////////////////////
    // HI/LO state
    ////////////////////

    // Architectural registers, visible to MFHI/MFLO
    logic [31:0] hiQ;
    logic [31:0] loQ;

    // Loaded on the same edge that samples the multiply
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            hiQ <= '0;
            loQ <= '0;
        end else if (we) begin
            // Upper product word
            hiQ <= product[63:32];
            // Lower product word
            loQ <= product[31:0];
        end
    end

    // Read path has no added latency
    assign hi = hiQ;
    assign lo = loQ;

endmodule

/* execStage.sv */
`timescale 1ns/1ps

module execStage (
    input  logic              Clk,
    input  logic              arstN,
    input  logic              inValid,
    input  logic [31:0]       instr,
    input  logic [31:0]       rsData,
    input  logic [31:0]       rtData,
    input  execPkg::decodedT  dec,
    input  logic [31:0]       hi,
    input  logic [31:0]       lo,
    output logic              hiLoWe,
    output logic [63:0]       product,
    output execPkg::execRespT resp
);
    import execPkg::*;

    logic [31:0] immExt;
    logic [31:0] opA;
    logic [31:0] opB;
    logic [4:0]  shamt;
    logic [63:0] aluResult;
    logic        aluZero;
    logic [31:0] nextResult;
    logic        nextZero;
    execRespT    nextResp;

    ////////////////////
    // Operand select
    ////////////////////

    // 16-bit immediate, sign or zero extended
    assign immExt = dec.immSigned ? {{16{instr[15]}}, instr[15:0]} : {16'b0, instr[15:0]};

    // Shifts act on rt
    assign opA   = dec.shiftRt ? rtData : rsData;
    assign opB   = dec.useImm ? immExt : rtData;
    // sa field or low bits of rs
    assign shamt = dec.varShift ? rsData[4:0] : instr[10:6];

    aluCore uAlu (
        .aluOp  (dec.aluOp),
        .a      (opA),
        .b      (opB),
        .shamt  (shamt),
        .result (aluResult),
        .zero   (aluZero)
    );

    // HI/LO load for a valid multiply only
    assign hiLoWe  = inValid & dec.hiLoWrite;
    assign product = aluResult;

    ////////////////////
    // Result select
    ////////////////////

    always_comb begin
        if (dec.readHi) begin
            nextResult = hi;
        end else if (dec.readLo) begin
            nextResult = lo;
        end else if (dec.illegal) begin
            nextResult = '0;
        end else begin
            nextResult = aluResult[31:0];
        end
    end

    // ALU flag is valid when the upper word is zero
    // Multiplies report only the low word
    assign nextZero = (dec.readHi | dec.readLo | dec.illegal | dec.hiLoWrite) ?
                      (nextResult == '0) : aluZero;

    always_comb begin
        // Idle cycles present an all-zero response
        nextResp = '0;
        if (inValid) begin
            nextResp.valid   = 1'b1;
            nextResp.result  = nextResult;
            nextResp.zero    = nextZero;
            nextResp.illegal = dec.illegal;
        end
    end

    // Output pipeline register, one cycle of latency
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            resp <= '0;
        end else begin
            resp <= nextResp;
        end
    end

endmodule

/* execTop.sv */
`timescale 1ns/1ps

module execTop (
    input  logic              Clk,
    input  logic              arstN,
    input  logic              inValid,
    input  logic [31:0]       instr,
    input  logic [31:0]       rsData,
    input  logic [31:0]       rtData,
    output execPkg::execRespT resp
);
    import execPkg::*;

    // Decode to stage
    decodedT     dec;
    // Stage to HI/LO
    logic        hiLoWe;
    logic [63:0] product;
    // HI/LO back to the result mux
    logic [31:0] hi;
    logic [31:0] lo;

    ////////////////////
    // Decode
    ////////////////////

    aluDecode uDecode (
        .instr (instr),
        .dec   (dec)
    );

    ////////////////////
    // Execute
    ////////////////////

    execStage uStage (
        .Clk     (Clk),
        .arstN   (arstN),
        .inValid (inValid),
        .instr   (instr),
        .rsData  (rsData),
        .rtData  (rtData),
        .dec     (dec),
        .hi      (hi),
        .lo      (lo),
        .hiLoWe  (hiLoWe),
        .product (product),
        .resp    (resp)
    );

    // Multiply product store
    hiLoRegs uHiLo (
        .Clk     (Clk),
        .arstN   (arstN),
        .we      (hiLoWe),
        .product (product),
        .hi      (hi),
        .lo      (lo)
    );

endmodule

/* execTb.sv */
`timescale 1ns/1ps

module execTb;
    import execPkg::*;

    localparam int ClkPeriod = 20;
    // Instruction counts per test group
    localparam int NumLatency = 4;
    localparam int NumRtype   = 10 * 8;
    localparam int NumImm     = 7 * 6 + 2 * 6;
    localparam int NumShift   = 7 * 32;
    localparam int NumMul     = 5 * 6;
    localparam int NumIllegal = 8;
    localparam int NumInstr   = NumLatency + NumRtype + NumImm + NumShift + NumMul + NumIllegal;

    // Expected response with its issue cycle
    typedef struct packed {
        execRespT    resp;
        logic [31:0] cycle;
    } expT;

    logic        Clk;
    logic        arstN;
    logic        inValid;
    logic [31:0] instr;
    logic [31:0] rsData;
    logic [31:0] rtData;
    execRespT    resp;

    integer      seed = 28799;
    logic [31:0] cycleCnt = '0;
    // Model copy of HI/LO
    logic [31:0] mHi;
    logic [31:0] mLo;
    expT         expQ[$];
    string       nameQ[$];
    int          valErrs = 0;
    int          protoErrs = 0;

    // Corner operands
    logic [31:0] edgeA [0:3] = '{32'h0, 32'hFFFF_FFFF, 32'h8000_0000, 32'h7FFF_FFFF};
    logic [31:0] edgeB [0:3] = '{32'h0, 32'hFFFF_FFFF, 32'h7FFF_FFFF, 32'h8000_0000};
    logic [5:0]  rFuncts [0:9] = '{6'h20, 6'h21, 6'h22, 6'h23, 6'h24,
                                   6'h25, 6'h26, 6'h27, 6'h2A, 6'h2B};
    logic [5:0]  iOps [0:6] = '{6'h08, 6'h09, 6'h0A, 6'h0B, 6'h0C, 6'h0D, 6'h0E};
    logic [15:0] immVals [0:3] = '{16'h0000, 16'h8000, 16'hFFFF, 16'h7FFF};
    // Last pair gives a zero low word under a nonzero high word
    logic [31:0] mulA [0:3] = '{32'hFFFF_FFFE, 32'h8000_0000, 32'hFFFF_FFFF, 32'h0001_0000};
    logic [31:0] mulB [0:3] = '{32'h0000_0003, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0001_0000};

    execTop UUT (
        .Clk     (Clk),
        .arstN   (arstN),
        .inValid (inValid),
        .instr   (instr),
        .rsData  (rsData),
        .rtData  (rtData),
        .resp    (resp)
    );

    ////////////////////
    // Clock and cycle count
    ////////////////////

    initial begin
        Clk = 1'b0;
        forever begin
            #(ClkPeriod / 2) Clk = ~Clk;
        end
    end

    always @(posedge Clk) begin
        cycleCnt <= cycleCnt + 1;
    end

    // Watchdog sized from the instruction count
    initial begin
        #((NumInstr + 50) * ClkPeriod);
        $display("Timeout: the run did not finish in time");
        $display("Verification failed");
        $finish;
    end

    ////////////////////
    // Encoders and model
    ////////////////////

    // SPECIAL word, rt=2 rd=3
    function automatic logic [31:0] rEncode(input logic [4:0] rsF, input logic [4:0] sa,
                                            input logic [5:0] fn);
        return {6'h00, rsF, 5'd2, 5'd3, sa, fn};
    endfunction

    // I-type word, rs=1 rt=2
    function automatic logic [31:0] iEncode(input logic [5:0] op, input logic [15:0] imm);
        return {op, 5'd1, 5'd2, imm};
    endfunction

    // One bit per step to the right
    function automatic logic [31:0] rotateRight(input logic [31:0] x, input logic [4:0] n);
        logic [31:0] v;
        v = x;
        for (int k = 0; k < n; k++) begin
            v = {v[0], v[31:1]};
        end
        return v;
    endfunction

    function automatic execRespT modelExec(input logic [31:0] ins, input logic [31:0] rs,
                                           input logic [31:0] rt, input logic [31:0] hiIn,
                                           input logic [31:0] loIn, output logic [31:0] hiOut,
                                           output logic [31:0] loOut);
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [4:0]  sa;
        logic [31:0] simm;
        logic [31:0] zimm;
        logic [63:0] prod;
        logic [31:0] res;
        logic        bad;
        execRespT    r;
        op    = ins[31:26];
        fn    = ins[5:0];
        sa    = ins[10:6];
        simm  = {{16{ins[15]}}, ins[15:0]};
        zimm  = {16'h0, ins[15:0]};
        hiOut = hiIn;
        loOut = loIn;
        res   = '0;
        bad   = 1'b0;
        case (op)
            6'h00: begin
                case (fn)
                    6'h20, 6'h21: res = rs + rt;
                    6'h22, 6'h23: res = rs - rt;
                    6'h24: res = rs & rt;
                    6'h25: res = rs | rt;
                    6'h26: res = rs ^ rt;
                    6'h27: res = ~(rs | rt);
                    6'h2A: res = ($signed(rs) < $signed(rt)) ? 32'd1 : 32'd0;
                    6'h2B: res = (rs < rt) ? 32'd1 : 32'd0;
                    6'h00: res = rt << sa;
                    // Bit 21 selects rotate
                    6'h02: res = ins[21] ? rotateRight(rt, sa) : (rt >> sa);
                    6'h03: res = $signed(rt) >>> sa;
                    6'h04: res = rt << rs[4:0];
                    // Bit 6 selects rotate
                    6'h06: res = ins[6] ? rotateRight(rt, rs[4:0]) : (rt >> rs[4:0]);
                    6'h18: begin
                        // Sign extended, product mod 2^64
                        prod  = {{32{rs[31]}}, rs} * {{32{rt[31]}}, rt};
                        hiOut = prod[63:32];
                        loOut = prod[31:0];
                        res   = prod[31:0];
                    end
                    6'h19: begin
                        prod  = {32'h0, rs} * {32'h0, rt};
                        hiOut = prod[63:32];
                        loOut = prod[31:0];
                        res   = prod[31:0];
                    end
                    6'h10: res = hiIn;
                    6'h12: res = loIn;
                    default: bad = 1'b1;
                endcase
            end
            6'h08, 6'h09: res = rs + simm;
            6'h0A: res = ($signed(rs) < $signed(simm)) ? 32'd1 : 32'd0;
            6'h0B: res = (rs < simm) ? 32'd1 : 32'd0;
            6'h0C: res = rs & zimm;
            6'h0D: res = rs | zimm;
            6'h0E: res = rs ^ zimm;
            6'h1F: begin
                if (fn == 6'h20 && sa == 5'h10) begin
                    res = {{24{rt[7]}}, rt[7:0]};
                end else if (fn == 6'h20 && sa == 5'h18) begin
                    res = {{16{rt[15]}}, rt[15:0]};
                end else begin
                    bad = 1'b1;
                end
            end
            default: bad = 1'b1;
        endcase
        if (bad) begin
            res = '0;
        end
        r.valid   = 1'b1;
        r.result  = res;
        r.zero    = (res == '0);
        r.illegal = bad;
        return r;
    endfunction

    ////////////////////
    // Stimulus tasks
    ////////////////////

    task automatic issue(input string name, input logic [31:0] ins, input logic [31:0] rs,
                         input logic [31:0] rt);
        expT         e;
        logic [31:0] nHi;
        logic [31:0] nLo;
        @(posedge Clk);
        #2;
        inValid = 1'b1;
        instr   = ins;
        rsData  = rs;
        rtData  = rt;
        e.resp  = modelExec(ins, rs, rt, mHi, mLo, nHi, nLo);
        e.cycle = cycleCnt;
        // HI/LO follow in issue order
        mHi     = nHi;
        mLo     = nLo;
        expQ.push_back(e);
        nameQ.push_back(name);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge Clk);
            #2;
            inValid = 1'b0;
            instr   = '0;
        end
    endtask

    ////////////////////
    // Compare process
    ////////////////////

    always @(negedge Clk) begin : compare
        expT   e;
        string nm;
        if (resp.valid) begin
            assert (expQ.size() > 0) else begin
                protoErrs++;
                $display("A response with valid high arrived while nothing was pending");
            end
            if (expQ.size() > 0) begin
                e  = expQ.pop_front();
                nm = nameQ.pop_front();
                assert (cycleCnt == e.cycle + 1) else begin
                    protoErrs++;
                    $display("Response for %s came %0d cycles after issue", nm,
                             cycleCnt - e.cycle);
                end
                assert (resp.result == e.resp.result) else begin
                    valErrs++;
                    $display("ERR %s result expected %h actual %h", nm, e.resp.result,
                             resp.result);
                end
                assert (resp.zero == e.resp.zero) else begin
                    valErrs++;
                    $display("ERR %s zero expected %b actual %b", nm, e.resp.zero, resp.zero);
                end
                assert (resp.illegal == e.resp.illegal) else begin
                    valErrs++;
                    $display("ERR %s illegal expected %b actual %b", nm, e.resp.illegal,
                             resp.illegal);
                end
            end
        end else if (expQ.size() > 0) begin
            // Overdue entry means a dropped response
            assert (cycleCnt <= expQ[0].cycle) else begin
                protoErrs++;
                e  = expQ.pop_front();
                nm = nameQ.pop_front();
                $display("No response for %s one cycle after issue", nm);
            end
        end
    end

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin : stimulus
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        inValid = 1'b0;
        instr   = '0;
        rsData  = '0;
        rtData  = '0;
        mHi     = '0;
        mLo     = '0;
        arstN   = 1'b0;
        repeat (8) @(posedge Clk);
        #2;
        arstN = 1'b1;
        @(negedge Clk);
        assert (resp == '0) else begin
            protoErrs++;
            $display("Response was not cleared by reset");
        end

        // Single issue, then three in a row
        issue("latency add", rEncode(5'd1, 5'd0, 6'h21), 32'd5, 32'd7);
        idle(3);
        issue("b2b add", rEncode(5'd1, 5'd0, 6'h20), $random(seed), $random(seed));
        issue("b2b sub", rEncode(5'd1, 5'd0, 6'h22), $random(seed), $random(seed));
        issue("b2b xor", rEncode(5'd1, 5'd0, 6'h26), $random(seed), $random(seed));
        idle(2);

        // R-type on corner then random operands
        for (int f = 0; f < 10; f++) begin
            for (int k = 0; k < 8; k++) begin
                a = (k < 4) ? edgeA[k] : $random(seed);
                b = (k < 4) ? edgeB[k] : $random(seed);
                issue($sformatf("rtype fn%02h", rFuncts[f]), rEncode(5'd1, 5'd0, rFuncts[f]),
                      a, b);
            end
        end
        idle(2);

        // Immediates, sign vs zero extension
        for (int o = 0; o < 7; o++) begin
            for (int k = 0; k < 6; k++) begin
                b = $random(seed);
                a = (k < 4) ? edgeA[k] : $random(seed);
                issue($sformatf("imm op%02h", iOps[o]),
                      iEncode(iOps[o], (k < 4) ? immVals[k] : b[15:0]), a, $random(seed));
            end
        end
        for (int k = 0; k < 6; k++) begin
            b = (k < 4) ? {16'h0, immVals[k]} ^ {24'h0, 8'h80} : $random(seed);
            issue("seb", {6'h1F, 5'd0, 5'd2, 5'd3, 5'h10, 6'h20}, $random(seed), b);
            issue("seh", {6'h1F, 5'd0, 5'd2, 5'd3, 5'h18, 6'h20}, $random(seed), b);
        end
        idle(2);

        // All 32 amounts, fixed and variable
        for (int s = 0; s < 32; s++) begin
            sh = s[4:0];
            a  = $random(seed);
            b  = $random(seed);
            issue($sformatf("sll %0d", s), rEncode(5'd0, sh, 6'h00), a, b);
            issue($sformatf("srl %0d", s), rEncode(5'd0, sh, 6'h02), a, b);
            issue($sformatf("sra %0d", s), rEncode(5'd0, sh, 6'h03), a, b);
            issue($sformatf("rotr %0d", s), rEncode(5'd1, sh, 6'h02), a, b);
            // Upper rs bits must be ignored
            a = {a[31:5], sh};
            issue($sformatf("sllv %0d", s), rEncode(5'd1, 5'd0, 6'h04), a, b);
            issue($sformatf("srlv %0d", s), rEncode(5'd1, 5'd0, 6'h06), a, b);
            issue($sformatf("rotrv %0d", s), rEncode(5'd1, 5'd1, 6'h06), a, b);
        end
        idle(2);

        // Multiply then read back at once
        for (int k = 0; k < 5; k++) begin
            a = (k < 4) ? mulA[k] : $random(seed);
            b = (k < 4) ? mulB[k] : $random(seed);
            issue("mult", rEncode(5'd1, 5'd0, 6'h18), a, b);
            issue("mfhi after mult", rEncode(5'd0, 5'd0, 6'h10), $random(seed), $random(seed));
            issue("mflo after mult", rEncode(5'd0, 5'd0, 6'h12), $random(seed), $random(seed));
            issue("multu", rEncode(5'd1, 5'd0, 6'h19), a, b);
            issue("mfhi after multu", rEncode(5'd0, 5'd0, 6'h10), $random(seed), $random(seed));
            issue("mflo after multu", rEncode(5'd0, 5'd0, 6'h12), $random(seed), $random(seed));
        end
        idle(2);

        // Undefined words, HI/LO must survive
        issue("illegal op3f", {6'h3F, 26'h0123456}, $random(seed), $random(seed));
        issue("illegal lw", {6'h23, 26'h0220010}, $random(seed), $random(seed));
        issue("illegal fn01", rEncode(5'd1, 5'd0, 6'h01), $random(seed), $random(seed));
        issue("illegal fn3f", rEncode(5'd1, 5'd0, 6'h3F), $random(seed), $random(seed));
        issue("illegal bshfl", {6'h1F, 5'd0, 5'd2, 5'd3, 5'h11, 6'h20}, $random(seed),
              $random(seed));
        issue("illegal spec3", {6'h1F, 5'd0, 5'd2, 5'd3, 5'h10, 6'h00}, $random(seed),
              $random(seed));
        issue("mfhi after illegal", rEncode(5'd0, 5'd0, 6'h10), $random(seed), $random(seed));
        issue("mflo after illegal", rEncode(5'd0, 5'd0, 6'h12), $random(seed), $random(seed));
        idle(5);

        assert (expQ.size() == 0) else begin
            protoErrs++;
            $display("%0d expected responses never arrived", expQ.size());
        end
        $display("Errors: value %0d, protocol %0d", valErrs, protoErrs);
        if (valErrs == 0 && protoErrs == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* compile.f */
execPkg.sv
aluCore.sv
aluDecode.sv
hiLoRegs.sv
execStage.sv
execTop.sv
execTb.sv

/* Makefile */
SIM       := verilator
TOP       := execTb
FILELIST  := compile.f
OBJDIR    := obj_dir
LOG       := sim.log
FLAGS     := --binary --timing --assert -Wno-fatal -Mdir $(OBJDIR) --top-module $(TOP)
LINTFLAGS := --lint-only --timing -Wall --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) -f $(FILELIST)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		echo "Simulation reported a failure"; exit 1; \
	fi
	@if ! grep -q "Verification passed" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

lint:
	$(SIM) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
